// File: hdl/stq_pkg.sv
package stq_pkg;

  localparam int stq_depth = 16;
  localparam int stq_idx_w = 4;

  localparam int addr_w  = 30; // word address
  localparam int bmask_w = 4;
  localparam int word_w  = 32;

  // queue slot, also used for pointers and load age
  typedef logic [stq_idx_w-1:0] stq_idx_t;

  // one bit per entry
  typedef logic [stq_depth-1:0] stq_vec_t;

  typedef logic [addr_w-1:0]  word_addr_t;
  typedef logic [bmask_w-1:0] bmask_t;
  typedef logic [word_w-1:0]  word_t;

endpackage

// File: hdl/stq_ctrl_if.sv
`timescale 1ns/1ps

interface stq_ctrl_if;

  stq_pkg::stq_vec_t   match_vec;   // valid, same word, overlapping bytes
  stq_pkg::stq_vec_t   cover_vec;   // match and all load bytes present
  stq_pkg::stq_vec_t   data_ok_vec;
  stq_pkg::word_addr_t head_addr;
  stq_pkg::bmask_t     head_bmask;
  stq_pkg::stq_idx_t   head_idx;
  logic                free_en;     // frees entry at head_idx

  modport array (
    output match_vec, cover_vec, data_ok_vec, head_addr, head_bmask,
    input  head_idx, free_en
  );

  modport select (
    input match_vec, cover_vec, data_ok_vec, head_idx
  );

  modport drain (
    output head_idx, free_en,
    input  data_ok_vec, head_addr, head_bmask
  );

endinterface

// File: hdl/stq_entry_array.sv
`timescale 1ns/1ps

module stq_entry_array (
  input  logic                clk,
  input  logic                rst,
  input  logic                st_addr_valid,
  input  stq_pkg::stq_idx_t   st_addr_idx,
  input  stq_pkg::word_addr_t st_addr,
  input  stq_pkg::bmask_t     st_bmask,
  input  logic                st_data_valid,
  input  stq_pkg::stq_idx_t   st_data_idx,
  input  stq_pkg::word_addr_t ld_addr,
  input  stq_pkg::bmask_t     ld_bmask,
  stq_ctrl_if.array           ctrl
);

  stq_pkg::word_addr_t addr_q [stq_pkg::stq_depth];
  stq_pkg::bmask_t     bmask_q [stq_pkg::stq_depth];
  stq_pkg::stq_vec_t   valid_q;
  stq_pkg::stq_vec_t   data_ok_q;
  stq_pkg::stq_vec_t   match_vec;
  stq_pkg::stq_vec_t   cover_vec;

  always_ff @(posedge clk) begin
    if (st_addr_valid) begin
      addr_q[st_addr_idx]  <= st_addr;
      bmask_q[st_addr_idx] <= st_bmask;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q   <= '0;
      data_ok_q <= '0;
    end else begin
      if (ctrl.free_en) begin
        valid_q[ctrl.head_idx] <= 1'b0;
      end
      if (st_addr_valid) begin
        valid_q[st_addr_idx]   <= 1'b1;
        data_ok_q[st_addr_idx] <= 1'b0; // new store, data not yet in
      end
      if (st_data_valid) begin
        data_ok_q[st_data_idx] <= 1'b1; // wins over same-cycle addr write
      end
    end
  end

  // one comparator per entry against the load
  for (genvar i = 0; i < stq_pkg::stq_depth; i++) begin : g_cmp
    assign match_vec[i] = valid_q[i] && (addr_q[i] == ld_addr) &&
                          ((bmask_q[i] & ld_bmask) != '0);
    assign cover_vec[i] = match_vec[i] && ((ld_bmask & ~bmask_q[i]) == '0);
  end

  assign ctrl.match_vec   = match_vec;
  assign ctrl.cover_vec   = cover_vec;
  assign ctrl.data_ok_vec = data_ok_q;
  assign ctrl.head_addr   = addr_q[ctrl.head_idx];
  assign ctrl.head_bmask  = bmask_q[ctrl.head_idx];

endmodule

// File: hdl/stq_data_array.sv
`timescale 1ns/1ps

module stq_data_array (
  input  logic              clk,
  input  logic              st_data_valid,
  input  stq_pkg::stq_idx_t st_data_idx,
  input  stq_pkg::word_t    st_data,
  input  stq_pkg::stq_idx_t fwd_idx,
  output stq_pkg::word_t    fwd_word,
  input  stq_pkg::stq_idx_t head_idx,
  output stq_pkg::word_t    head_word
);

  stq_pkg::word_t mem [stq_pkg::stq_depth];

  always_ff @(posedge clk) begin
    if (st_data_valid) begin
      mem[st_data_idx] <= st_data;
    end
  end

  // two async read ports
  assign fwd_word  = mem[fwd_idx];  // load forwarding
  assign head_word = mem[head_idx]; // writeback

endmodule

// File: hdl/stq_fwd_select.sv
`timescale 1ns/1ps

module stq_fwd_select (
  input  logic              clk,
  input  logic              rst,
  input  logic              ld_valid,
  input  stq_pkg::stq_idx_t ld_age,
  stq_ctrl_if.select        ctrl,
  output stq_pkg::stq_idx_t fwd_idx,
  input  stq_pkg::word_t    fwd_word,
  output logic              fwd_valid,
  output logic              fwd_hit,
  output logic              fwd_stall,
  output stq_pkg::word_t    fwd_data
);

  stq_pkg::stq_vec_t below_age;
  stq_pkg::stq_vec_t from_head;
  stq_pkg::stq_vec_t win_lo;
  stq_pkg::stq_vec_t win_hi;
  logic              wrap;
  logic              any_match;
  logic              hit;
  logic              stall;

  function automatic stq_pkg::stq_idx_t last_set(stq_pkg::stq_vec_t vec);
    stq_pkg::stq_idx_t idx;
    idx = '0;
    for (int i = 0; i < stq_pkg::stq_depth; i++) begin
      if (vec[i]) idx = stq_pkg::stq_idx_t'(i);
    end
    return idx;
  endfunction

  always_comb begin
    for (int i = 0; i < stq_pkg::stq_depth; i++) begin
      below_age[i] = stq_pkg::stq_idx_t'(i) < ld_age;
      from_head[i] = stq_pkg::stq_idx_t'(i) >= ctrl.head_idx;
    end
  end

  // window wraps past the last entry
  assign wrap   = ld_age < ctrl.head_idx;
  assign win_lo = wrap ? (ctrl.match_vec & below_age) : (ctrl.match_vec & below_age & from_head);
  assign win_hi = wrap ? (ctrl.match_vec & from_head) : '0;

  // youngest older store: low side first, then the wrapped part
  assign fwd_idx   = (win_lo != '0) ? last_set(win_lo) : last_set(win_hi);
  assign any_match = (win_lo != '0) || (win_hi != '0);
  assign hit       = any_match && ctrl.cover_vec[fwd_idx] && ctrl.data_ok_vec[fwd_idx];
  assign stall     = any_match && !hit; // partial or data missing

  always_ff @(posedge clk) begin
    if (rst) begin
      fwd_valid <= 1'b0;
      fwd_hit   <= 1'b0;
      fwd_stall <= 1'b0;
    end else begin
      fwd_valid <= ld_valid;
      fwd_hit   <= ld_valid && hit;
      fwd_stall <= ld_valid && stall;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_valid) begin
      fwd_data <= fwd_word;
    end
  end

endmodule

// File: hdl/stq_drain.sv
`timescale 1ns/1ps

module stq_drain (
  input  logic                clk,
  input  logic                rst,
  input  logic                commit_valid,
  stq_ctrl_if.drain           ctrl,
  input  stq_pkg::word_t      head_word,
  output logic                wb_valid,
  input  logic                wb_ready,
  output stq_pkg::word_addr_t wb_addr,
  output stq_pkg::bmask_t     wb_bmask,
  output stq_pkg::word_t      wb_data
);

  stq_pkg::stq_idx_t             head_ptr;
  stq_pkg::stq_idx_t             cmt_ptr;
  logic                          head_phase; // wrap bits tell full from empty
  logic                          cmt_phase;
  logic [stq_pkg::stq_idx_w:0]   pend_cnt;   // committed, not yet drained
  logic                          handshake;
  logic                          load_wb;

  assign pend_cnt  = {cmt_phase, cmt_ptr} - {head_phase, head_ptr};
  assign handshake = wb_valid && wb_ready;
  assign load_wb   = !wb_valid && (pend_cnt != '0) && ctrl.data_ok_vec[head_ptr];

  assign ctrl.head_idx = head_ptr;
  assign ctrl.free_en  = handshake;

  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr   <= '0;
      head_phase <= 1'b0;
      cmt_ptr    <= '0;
      cmt_phase  <= 1'b0;
      wb_valid   <= 1'b0;
    end else begin
      if (commit_valid) begin
        {cmt_phase, cmt_ptr} <= {cmt_phase, cmt_ptr} + 1'b1;
      end
      if (handshake) begin
        {head_phase, head_ptr} <= {head_phase, head_ptr} + 1'b1;
        wb_valid               <= 1'b0;
      end else if (load_wb) begin
        wb_valid <= 1'b1;
      end
    end
  end

  // held stable while wb_valid waits for ready
  always_ff @(posedge clk) begin
    if (load_wb) begin
      wb_addr  <= ctrl.head_addr;
      wb_bmask <= ctrl.head_bmask;
      wb_data  <= head_word;
    end
  end

endmodule

// File: hdl/stq_top.sv
`timescale 1ns/1ps

module stq_top (
  input  logic                clk,
  input  logic                rst,
  // store address write
  input  logic                st_addr_valid,
  input  stq_pkg::stq_idx_t   st_addr_idx,
  input  stq_pkg::word_addr_t st_addr,
  input  stq_pkg::bmask_t     st_bmask,
  // store data write
  input  logic                st_data_valid,
  input  stq_pkg::stq_idx_t   st_data_idx,
  input  stq_pkg::word_t      st_data,
  // load lookup
  input  logic                ld_valid,
  input  stq_pkg::word_addr_t ld_addr,
  input  stq_pkg::bmask_t     ld_bmask,
  input  stq_pkg::stq_idx_t   ld_age,
  output logic                fwd_valid,
  output logic                fwd_hit,
  output logic                fwd_stall,
  output stq_pkg::word_t      fwd_data,
  // commit
  input  logic                commit_valid,
  // writeback to cache
  output logic                wb_valid,
  input  logic                wb_ready,
  output stq_pkg::word_addr_t wb_addr,
  output stq_pkg::bmask_t     wb_bmask,
  output stq_pkg::word_t      wb_data
);

  stq_pkg::stq_idx_t fwd_idx;
  stq_pkg::word_t    fwd_word;
  stq_pkg::word_t    head_word;

  stq_ctrl_if ctrl_i ();

  stq_entry_array entry_i (
    .clk           (clk),
    .rst           (rst),
    .st_addr_valid (st_addr_valid),
    .st_addr_idx   (st_addr_idx),
    .st_addr       (st_addr),
    .st_bmask      (st_bmask),
    .st_data_valid (st_data_valid),
    .st_data_idx   (st_data_idx),
    .ld_addr       (ld_addr),
    .ld_bmask      (ld_bmask),
    .ctrl          (ctrl_i.array)
  );

  stq_data_array data_i (
    .clk           (clk),
    .st_data_valid (st_data_valid),
    .st_data_idx   (st_data_idx),
    .st_data       (st_data),
    .fwd_idx       (fwd_idx),
    .fwd_word      (fwd_word),
    .head_idx      (ctrl_i.head_idx),
    .head_word     (head_word)
  );

  stq_fwd_select select_i (
    .clk       (clk),
    .rst       (rst),
    .ld_valid  (ld_valid),
    .ld_age    (ld_age),
    .ctrl      (ctrl_i.select),
    .fwd_idx   (fwd_idx),
    .fwd_word  (fwd_word),
    .fwd_valid (fwd_valid),
    .fwd_hit   (fwd_hit),
    .fwd_stall (fwd_stall),
    .fwd_data  (fwd_data)
  );

  stq_drain drain_i (
    .clk          (clk),
    .rst          (rst),
    .commit_valid (commit_valid),
    .ctrl         (ctrl_i.drain),
    .head_word    (head_word),
    .wb_valid     (wb_valid),
    .wb_ready     (wb_ready),
    .wb_addr      (wb_addr),
    .wb_bmask     (wb_bmask),
    .wb_data      (wb_data)
  );

endmodule

// File: verification/stq_tb_clk.sv
`timescale 1ns/1ps

module stq_tb_clk (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: verification/stq_assertions.sv
`timescale 1ns/1ps

module stq_assertions (
  input logic                clk,
  input logic                rst,
  input logic                ld_valid,
  input logic                fwd_valid,
  input logic                fwd_hit,
  input logic                fwd_stall,
  input logic                wb_valid,
  input logic                wb_ready,
  input stq_pkg::word_addr_t wb_addr,
  input stq_pkg::bmask_t     wb_bmask,
  input stq_pkg::word_t      wb_data
);

  // offered writeback is held until the cache takes it
  wb_hold: assert property (@(posedge clk) disable iff (rst)
    wb_valid && !wb_ready |=> wb_valid && $stable(wb_addr) &&
                              $stable(wb_bmask) && $stable(wb_data))
    else $error("writeback dropped or changed before wb_ready");

  hit_or_stall: assert property (@(posedge clk) disable iff (rst) !(fwd_hit && fwd_stall))
    else $error("fwd_hit and fwd_stall high in the same cycle");

  fwd_after_ld: assert property (@(posedge clk) disable iff (rst) fwd_valid |-> $past(ld_valid))
    else $error("fwd_valid without a load one cycle earlier");

endmodule

bind stq_top stq_assertions asrt_i (
  .clk(clk), .rst(rst), .ld_valid(ld_valid), .fwd_valid(fwd_valid),
  .fwd_hit(fwd_hit), .fwd_stall(fwd_stall), .wb_valid(wb_valid), .wb_ready(wb_ready),
  .wb_addr(wb_addr), .wb_bmask(wb_bmask), .wb_data(wb_data)
);

// File: verification/stq_tb.sv
`timescale 1ns/1ps

module stq_tb;

  logic                clk;
  logic                rst;
  logic                st_addr_valid;
  stq_pkg::stq_idx_t   st_addr_idx;
  stq_pkg::word_addr_t st_addr;
  stq_pkg::bmask_t     st_bmask;
  logic                st_data_valid;
  stq_pkg::stq_idx_t   st_data_idx;
  stq_pkg::word_t      st_data;
  logic                ld_valid;
  stq_pkg::word_addr_t ld_addr;
  stq_pkg::bmask_t     ld_bmask;
  stq_pkg::stq_idx_t   ld_age;
  logic                fwd_valid;
  logic                fwd_hit;
  logic                fwd_stall;
  stq_pkg::word_t      fwd_data;
  logic                commit_valid;
  logic                wb_valid;
  logic                wb_ready;
  stq_pkg::word_addr_t wb_addr;
  stq_pkg::bmask_t     wb_bmask;
  stq_pkg::word_t      wb_data;

  // reference copy of the queue
  logic                m_valid   [stq_pkg::stq_depth];
  logic                m_data_ok [stq_pkg::stq_depth];
  stq_pkg::word_addr_t m_addr    [stq_pkg::stq_depth];
  stq_pkg::bmask_t     m_bmask   [stq_pkg::stq_depth];
  stq_pkg::word_t      m_data    [stq_pkg::stq_depth];
  stq_pkg::stq_idx_t   m_head;
  stq_pkg::stq_idx_t   alloc_idx;
  int                  m_pending; // committed and not yet drained

  logic [15:0] lfsr_q;
  string       cur_test;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_bad;
  int          checks;

  stq_tb_clk clk_i (.clk(clk), .rst(rst));

  stq_top dut_i (.*);

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic stq_pkg::word_t byte_bits(stq_pkg::bmask_t m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  // walk back from ld_age toward the head until the first overlap
  function automatic int youngest_older(stq_pkg::word_addr_t addr, stq_pkg::bmask_t mask,
                                        stq_pkg::stq_idx_t age);
    stq_pkg::stq_idx_t span;
    stq_pkg::stq_idx_t idx;
    span = age - m_head;
    idx  = age;
    repeat (span) begin
      idx = idx - 4'd1;
      if (m_valid[idx] && m_addr[idx] == addr && (m_bmask[idx] & mask) != '0) return int'(idx);
    end
    return -1;
  endfunction

  task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (act == exp) else begin
      $display("FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic report_error(string msg);
    $display("%s: %s", cur_test, msg);
    test_errors++;
  endtask

  task automatic begin_test(string name);
    cur_test    = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      $display("[%0t] %s: ok", $time, cur_test);
    end else begin
      $display("[%0t] %s: %0d errors", $time, cur_test, test_errors);
      tests_bad++;
    end
    total_errors += test_errors;
  endtask

  task automatic write_store(stq_pkg::word_addr_t addr, stq_pkg::bmask_t mask,
                             stq_pkg::word_t data, bit with_data);
    @(posedge clk);
    st_addr_valid <= 1'b1;
    st_addr_idx   <= alloc_idx;
    st_addr       <= addr;
    st_bmask      <= mask;
    st_data_valid <= with_data;
    st_data_idx   <= alloc_idx;
    st_data       <= data;
    m_valid[alloc_idx]   = 1'b1;
    m_addr[alloc_idx]    = addr;
    m_bmask[alloc_idx]   = mask;
    m_data[alloc_idx]    = data;
    m_data_ok[alloc_idx] = with_data;
    alloc_idx = alloc_idx + 4'd1;
    @(posedge clk);
    st_addr_valid <= 1'b0;
    st_data_valid <= 1'b0;
  endtask

  task automatic write_data(stq_pkg::stq_idx_t idx, stq_pkg::word_t data);
    @(posedge clk);
    st_data_valid <= 1'b1;
    st_data_idx   <= idx;
    st_data       <= data;
    m_data[idx]    = data;
    m_data_ok[idx] = 1'b1;
    @(posedge clk);
    st_data_valid <= 1'b0;
  endtask

  task automatic check_load(stq_pkg::word_addr_t addr, stq_pkg::bmask_t mask,
                            stq_pkg::stq_idx_t age);
    int                found;
    stq_pkg::stq_idx_t sel;
    logic              exp_hit;
    stq_pkg::word_t    keep;
    found   = youngest_older(addr, mask, age);
    sel     = stq_pkg::stq_idx_t'(found);
    exp_hit = found >= 0 && (mask & ~m_bmask[sel]) == '0 && m_data_ok[sel];
    keep    = byte_bits(mask);
    @(posedge clk);
    ld_valid <= 1'b1;
    ld_addr  <= addr;
    ld_bmask <= mask;
    ld_age   <= age;
    @(posedge clk);
    ld_valid <= 1'b0;
    @(negedge clk);
    check_value("fwd_valid", 32'd1, 32'(fwd_valid));
    check_value("fwd_hit", 32'(exp_hit), 32'(fwd_hit));
    check_value("fwd_stall", 32'(found >= 0 && !exp_hit), 32'(fwd_stall));
    if (exp_hit) check_value("fwd_data", m_data[sel] & keep, fwd_data & keep);
    @(negedge clk);
    check_value("fwd_valid after one cycle", 32'd0, 32'(fwd_valid));
  endtask

  // commits and wb_ready both follow the LFSR
  task automatic commit_and_drain(int n);
    int   left;
    int   drained;
    int   cycles;
    logic want;
    left    = n;
    drained = 0;
    cycles  = 0;
    while (drained < n && cycles < 24 * n + 40) begin
      @(posedge clk);
      want = lfsr_bit() && left > 0;
      commit_valid <= want;
      if (want) begin
        left--;
        m_pending++;
      end
      wb_ready <= lfsr_bit();
      @(negedge clk);
      cycles++;
      assert (!(wb_valid && m_pending == 0)) else report_error("wb_valid with nothing committed");
      if (wb_valid && wb_ready) begin
        check_value("wb_addr", 32'(m_addr[m_head]), 32'(wb_addr));
        check_value("wb_bmask", 32'(m_bmask[m_head]), 32'(wb_bmask));
        check_value("wb_data", m_data[m_head], wb_data);
        m_valid[m_head] = 1'b0;
        m_head = m_head + 4'd1;
        m_pending--;
        drained++;
      end
    end
    @(posedge clk);
    commit_valid <= 1'b0;
    wb_ready     <= 1'b0;
    assert (drained == n) else report_error($sformatf("only %0d of %0d stores drained", drained, n));
  endtask

  task automatic idle_after_reset();
    begin_test("reset_idle");
    @(negedge clk);
    check_value("wb_valid", 32'd0, 32'(wb_valid));
    check_value("fwd_valid", 32'd0, 32'(fwd_valid));
    check_load(30'h0000100, 4'hF, 4'd0);
    check_load(30'h0000100, 4'h3, 4'd8); // nothing valid in the window
    end_test();
  endtask

  task automatic forward_full_word();
    begin_test("full_forward");
    write_store(30'h0000100, 4'hF, 32'h1111_aaaa, 1'b1); // idx 0
    check_load(30'h0000100, 4'h3, 4'd1);
    check_load(30'h0000100, 4'hF, 4'd1);
    check_load(30'h0000100, 4'hC, 4'd0); // store is younger than the load
    end_test();
  endtask

  task automatic age_ordered_forward();
    begin_test("age_order");
    write_store(30'h0000100, 4'hF, 32'h2222_bbbb, 1'b1);
    write_store(30'h0000100, 4'hF, 32'h3333_cccc, 1'b1);
    write_store(30'h0000100, 4'hF, 32'h4444_dddd, 1'b1); // younger store at idx 3
    check_load(30'h0000100, 4'hF, 4'd3);
    check_load(30'h0000100, 4'h1, 4'd4);
    commit_and_drain(4);
    for (int i = 0; i < 10; i++) begin
      write_store(30'h0000200 + 30'(i), 4'hF, 32'h5000_0000 + i, 1'b1);
    end
    commit_and_drain(10); // head now at 14
    write_store(30'h0000333, 4'hF, 32'hee14_0014, 1'b1);
    write_store(30'h0000333, 4'hF, 32'hee15_0015, 1'b1);
    write_store(30'h0000333, 4'hC, 32'hee00_0000, 1'b1); // idx 0 after wrap
    write_store(30'h0000333, 4'hF, 32'hee01_0001, 1'b1);
    check_load(30'h0000333, 4'h3, 4'd1);
    check_load(30'h0000333, 4'hC, 4'd1);
    check_load(30'h0000333, 4'h3, 4'd2);
    check_load(30'h0000333, 4'hF, 4'd15);
    commit_and_drain(4);
    end_test();
  endtask

  task automatic stall_on_partial();
    begin_test("stall");
    write_store(30'h0000444, 4'h3, 32'h6666_1234, 1'b1);
    check_load(30'h0000444, 4'hF, 4'd3); // partial cover
    check_load(30'h0000444, 4'h1, 4'd3);
    write_store(30'h0000555, 4'hF, 32'h0, 1'b0);
    check_load(30'h0000555, 4'hF, 4'd4); // data missing
    write_data(4'd3, 32'h7777_5678);
    check_load(30'h0000555, 4'hF, 4'd4);
    end_test();
  endtask

  task automatic drain_in_order();
    begin_test("drain");
    for (int i = 0; i < 6; i++) begin
      write_store(30'h0000600 + 30'(i), 4'hF ^ 4'(i), 32'h8800_0000 + i, 1'b1);
    end
    commit_and_drain(8);
    // window still spans the freed slots
    check_load(30'h0000600, 4'h1, 4'd5);
    check_load(30'h0000444, 4'h1, 4'd5);
    @(negedge clk);
    check_value("wb_valid idle", 32'd0, 32'(wb_valid));
    end_test();
  endtask

  initial begin : watchdog
    int budget;
    // worst case cycles of each test plus slack
    budget = 10 + 14 + 620 + 22 + 260 + 300;
    #(budget * 20);
    $display("watchdog: run did not finish within %0d cycles", budget);
    $display("test failed");
    $finish;
  end

  initial begin
    st_addr_valid <= 1'b0;
    st_addr_idx   <= '0;
    st_addr       <= '0;
    st_bmask      <= '0;
    st_data_valid <= 1'b0;
    st_data_idx   <= '0;
    st_data       <= '0;
    ld_valid      <= 1'b0;
    ld_addr       <= '0;
    ld_bmask      <= '0;
    ld_age        <= '0;
    commit_valid  <= 1'b0;
    wb_ready      <= 1'b0;
    for (int i = 0; i < stq_pkg::stq_depth; i++) begin
      m_valid[stq_pkg::stq_idx_t'(i)]   = 1'b0;
      m_data_ok[stq_pkg::stq_idx_t'(i)] = 1'b0;
    end
    m_head       = '0;
    alloc_idx    = '0;
    m_pending    = 0;
    lfsr_q       = 16'd33998;
    total_errors = 0;
    tests_run    = 0;
    tests_bad    = 0;
    checks       = 0;
    @(negedge rst);
    idle_after_reset();
    forward_full_word();
    age_ordered_forward();
    stall_on_partial();
    drain_in_order();
    $display("tests %0d, failing %0d, checks %0d, errors %0d",
             tests_run, tests_bad, checks, total_errors);
    if (total_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: list.f
hdl/stq_pkg.sv
hdl/stq_ctrl_if.sv
hdl/stq_entry_array.sv
hdl/stq_data_array.sv
hdl/stq_fwd_select.sv
hdl/stq_drain.sv
hdl/stq_top.sv
verification/stq_tb_clk.sv
verification/stq_assertions.sv
verification/stq_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
build=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module stq_tb -f list.f -Mdir "$build" -o stq_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$build/stq_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$log"; then
  exit 0
fi
exit 1
